// File: sd_pkg.sv
package sd_pkg;

	//////////////////////////////////////////////////
	// block geometry
	//////////////////////////////////////////////////

	localparam int NUM_LINES   = 4;
	localparam int BLOCK_BYTES = 4;
	localparam int DATA_BITS   = 8;   // per line per block
	localparam int CRC_BITS    = 16;  // per line
	localparam int WORD_BITS   = BLOCK_BYTES * 8;

	localparam logic [CRC_BITS-1:0] CRC_POLY = 16'h1021;  // x^16+x^12+x^5+1

	// sequencer bit counter, start at 0, then data, crc, end and flush
	localparam int                CNT_W       = 5;
	localparam logic [CNT_W-1:0] CNT_DATA_LO = CNT_W'(1);
	localparam logic [CNT_W-1:0] CNT_DATA_HI = CNT_W'(DATA_BITS);
	localparam logic [CNT_W-1:0] CNT_CRC_HI  = CNT_W'(DATA_BITS + CRC_BITS);
	localparam logic [CNT_W-1:0] CNT_END     = CNT_W'(DATA_BITS + CRC_BITS + 1);
	localparam logic [CNT_W-1:0] CNT_FLUSH   = CNT_W'(DATA_BITS + CRC_BITS + 2);

	// line phase codes
	localparam logic [1:0] PH_START = 2'b00;  // drives 0
	localparam logic [1:0] PH_END   = 2'b01;  // drives 1
	localparam logic [1:0] PH_DATA  = 2'b10;
	localparam logic [1:0] PH_CRC   = 2'b11;

	//////////////////////////////////////////////////
	// apb register map
	//////////////////////////////////////////////////

	localparam int                 APB_AW      = 8;
	localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_TXDATA = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_RXDATA = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;

	typedef struct packed {
		logic                 tx_start;  // one-cycle pulse
		logic                 rx_arm;    // one-cycle pulse
		logic [WORD_BITS-1:0] tx_word;
	} seq_cmd_t;

	typedef struct packed {
		logic [1:0] phase;
		logic       oe;
		logic       data_sel;      // 0 selects the first bit of a pair
		logic       crc_rst;
		logic       crc_check_en;
	} line_ctrl_t;

	typedef struct packed {
		logic                 busy;
		logic                 tx_done;
		logic                 rx_done;
		logic [NUM_LINES-1:0] crc_err;
		logic [WORD_BITS-1:0] rx_word;
	} rx_status_t;

endpackage

// File: crc16.sv
`timescale 1ns/1ps

// serial crc16, folds data in then shifts the remainder out
module crc16 (
	input  logic clk,
	input  logic rst,
	input  logic gen_en,
	input  logic out_en,
	input  logic din,
	output logic dout
);

	logic [sd_pkg::CRC_BITS-1:0] crc;
	logic                        fb;

	assign fb   = din ^ crc[sd_pkg::CRC_BITS-1];
	assign dout = crc[sd_pkg::CRC_BITS-1];  // msb leads on shift-out

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			crc <= '0;
		else if (gen_en)
			crc <= {crc[sd_pkg::CRC_BITS-2:0], 1'b0} ^ (fb ? sd_pkg::CRC_POLY : '0);
		else if (out_en)
			crc <= {crc[sd_pkg::CRC_BITS-2:0], 1'b0};  // plain shift, remainder goes out
	end

endmodule

// File: sd_dat_line.sv
`timescale 1ns/1ps

module sd_dat_line (
	input  logic               clk,
	input  logic               rst,
	input  sd_pkg::line_ctrl_t ctrl,
	input  logic [1:0]         tx_bits,
	input  logic               dat_i,
	output logic               dat_o,
	output logic               dat_oe,
	output logic [1:0]         rcv_data,
	output logic               crc_error
);

	logic       sdata;
	logic       dout;
	logic       crc_din;
	logic       crc_dout;
	logic       gen_en;
	logic       out_en;
	logic       crc_clr;
	logic [1:0] dat_dly;

	assign sdata    = ctrl.data_sel ? tx_bits[0] : tx_bits[1];
	assign gen_en   = (ctrl.phase == sd_pkg::PH_DATA);
	assign out_en   = (ctrl.phase == sd_pkg::PH_CRC);
	assign crc_din  = ctrl.crc_check_en ? dat_dly[0] : dout;  // card bits when receiving
	assign crc_clr  = rst | ctrl.crc_rst;
	assign rcv_data = dat_dly;

	// bit to put on the line this cycle
	always_comb
	begin
		case (ctrl.phase)
			sd_pkg::PH_END:  dout = 1'b1;
			sd_pkg::PH_DATA: dout = sdata;
			sd_pkg::PH_CRC:  dout = crc_dout;
			default:         dout = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// pin side
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dat_o  <= 1'b0;
			dat_oe <= 1'b0;
		end
		else
		begin
			dat_o  <= dout;
			dat_oe <= ctrl.oe;
		end
	end

	// sample only while the host is not driving
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			dat_dly <= 2'b11;  // bus idles high
		else if (!dat_oe)
			dat_dly <= {dat_dly[0], dat_i};
	end

	// compare received crc bit against local remainder
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			crc_error <= 1'b0;
		else if (!ctrl.crc_check_en)
			crc_error <= 1'b0;
		else if (out_en && (crc_dout != dat_dly[0]))
			crc_error <= 1'b1;  // sticky until checking ends
	end

	crc16 u_crc (
		.clk    (clk),
		.rst    (crc_clr),
		.gen_en (gen_en),
		.out_en (out_en),
		.din    (crc_din),
		.dout   (crc_dout)
	);

endmodule

// File: sd_apb_regs.sv
`timescale 1ns/1ps

module sd_apb_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [sd_pkg::APB_AW-1:0] paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	output sd_pkg::seq_cmd_t          cmd,
	input  sd_pkg::rx_status_t        status,
	output logic [1:0]                done_clr
);

	logic        access;
	logic        wr_en;
	logic        rd_en;
	logic        sel_ctrl;
	logic        sel_tx;
	logic        sel_rx;
	logic        sel_stat;
	logic        mapped;
	logic        tx_start_q;
	logic        rx_arm_q;
	logic [31:0] txdata;

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	assign access   = psel & penable;  // access phase
	assign wr_en    = access & pwrite;
	assign rd_en    = access & ~pwrite;
	assign sel_ctrl = (paddr == sd_pkg::ADDR_CTRL);
	assign sel_tx   = (paddr == sd_pkg::ADDR_TXDATA);
	assign sel_rx   = (paddr == sd_pkg::ADDR_RXDATA);
	assign sel_stat = (paddr == sd_pkg::ADDR_STATUS);
	assign mapped   = sel_ctrl | sel_tx | sel_rx | sel_stat;

	assign pready  = 1'b1;  // zero wait states
	assign pslverr = access & ~mapped;

	// ctrl writes turn into single-cycle pulses, dropped while busy
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_start_q <= 1'b0;
			rx_arm_q   <= 1'b0;
		end
		else
		begin
			tx_start_q <= wr_en & sel_ctrl & pwdata[0] & ~status.busy;
			rx_arm_q   <= wr_en & sel_ctrl & pwdata[1] & ~status.busy;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			txdata <= '0;
		else if (wr_en & sel_tx)
			txdata <= pwdata;
	end

	assign cmd = '{tx_start: tx_start_q, rx_arm: rx_arm_q, tx_word: txdata};

	// write 1 to clear, bit 1 is tx_done and bit 2 is rx_done
	assign done_clr[0] = wr_en & sel_stat & pwdata[1];
	assign done_clr[1] = wr_en & sel_stat & pwdata[2];

	//////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////

	always_comb
	begin
		prdata = '0;
		if (rd_en)
		begin
			if (sel_tx)
				prdata = txdata;
			else if (sel_rx)
				prdata = status.rx_word;
			else if (sel_stat)
				prdata = {24'b0, status.crc_err, 1'b0, status.rx_done,
					status.tx_done, status.busy};
		end
	end

endmodule

// File: sd_block_seq.sv
`timescale 1ns/1ps

module sd_block_seq (
	input  logic                          clk,
	input  logic                          rst,
	input  sd_pkg::seq_cmd_t              cmd,
	input  logic                          dat_start,
	output sd_pkg::line_ctrl_t            line_ctrl,
	output logic [2*sd_pkg::NUM_LINES-1:0] tx_bits,
	output logic                          busy,
	output logic                          tx_end,
	output logic                          rx_end
);

	typedef enum logic [1:0] {S_IDLE, S_TX, S_RX_WAIT, S_RX} state_t;

	state_t                         state;
	logic [sd_pkg::CNT_W-1:0]      cnt;
	logic                           crc_rst_q;
	logic [sd_pkg::WORD_BITS-1:0]  tx_shift;
	logic [7:0]                     cur_byte;
	logic                           run;
	logic                           in_data;
	logic                           in_crc;
	logic                           in_end;

	assign run     = (state == S_TX) || (state == S_RX);
	assign in_data = run && (cnt >= sd_pkg::CNT_DATA_LO) && (cnt <= sd_pkg::CNT_DATA_HI);
	assign in_crc  = run && (cnt > sd_pkg::CNT_DATA_HI) && (cnt <= sd_pkg::CNT_CRC_HI);
	assign in_end  = run && (cnt == sd_pkg::CNT_END);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= S_IDLE;
			cnt       <= '0;
			crc_rst_q <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (cmd.tx_start)  // transmit wins over arm
					begin
						state     <= S_TX;
						cnt       <= '0;
						crc_rst_q <= 1'b1;
					end
					else if (cmd.rx_arm)
					begin
						state     <= S_RX_WAIT;
						crc_rst_q <= 1'b1;  // held until the start bit shows
					end
				S_TX:
				begin
					crc_rst_q <= 1'b0;
					if (cnt == sd_pkg::CNT_FLUSH)
						state <= S_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				S_RX_WAIT:
					if (dat_start)
					begin
						state     <= S_RX;
						cnt       <= sd_pkg::CNT_DATA_LO;
						crc_rst_q <= 1'b0;
					end
				default:  // S_RX
					if (cnt == sd_pkg::CNT_END)
						state <= S_IDLE;
					else
						cnt <= cnt + 1'b1;
			endcase
		end
	end

	// word latch, one byte consumed per bit pair
	always_ff @(posedge clk)
	begin
		if ((state == S_IDLE) && cmd.tx_start)
			tx_shift <= cmd.tx_word;
		else if ((state == S_TX) && in_data && !cnt[0])
			tx_shift <= tx_shift >> 8;
	end

	assign cur_byte = tx_shift[7:0];

	// line k sends byte bit k+4 first, then bit k
	always_comb
	begin
		for (int k = 0; k < sd_pkg::NUM_LINES; k++)
		begin
			tx_bits[2*k+1] = cur_byte[k+4];
			tx_bits[2*k]   = cur_byte[k];
		end
	end

	always_comb
	begin
		if (in_data)
			line_ctrl.phase = sd_pkg::PH_DATA;
		else if (in_crc)
			line_ctrl.phase = sd_pkg::PH_CRC;
		else if (in_end)
			line_ctrl.phase = sd_pkg::PH_END;
		else
			line_ctrl.phase = sd_pkg::PH_START;  // also idle, line parks at 0
		line_ctrl.oe           = (state == S_TX) && (cnt != sd_pkg::CNT_FLUSH);
		line_ctrl.data_sel     = ~cnt[0];
		line_ctrl.crc_rst      = crc_rst_q;
		line_ctrl.crc_check_en = (state == S_RX);
	end

	assign busy   = (state != S_IDLE);
	assign tx_end = (state == S_TX) && (cnt == sd_pkg::CNT_FLUSH);
	assign rx_end = (state == S_RX) && in_end;

endmodule

// File: sd_rx_result.sv
`timescale 1ns/1ps

module sd_rx_result (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [2*sd_pkg::NUM_LINES-1:0] rcv_data,
	input  logic [sd_pkg::NUM_LINES-1:0]   crc_error,
	input  logic                           busy,
	input  logic                           tx_end,
	input  logic                           rx_end,
	input  logic                           data_phase,
	input  logic [1:0]                     done_clr,
	output sd_pkg::rx_status_t             status
);

	logic                          pair_valid;  // second bit of a pair is on the lines
	logic [7:0]                    rx_byte;
	logic [sd_pkg::WORD_BITS-1:0] rx_shift;
	logic [sd_pkg::WORD_BITS-1:0] rx_word;
	logic [sd_pkg::NUM_LINES-1:0] crc_err;
	logic                          tx_done;
	logic                          rx_done;

	// undo the transmit mapping, older sample holds bit k+4
	always_comb
	begin
		for (int k = 0; k < sd_pkg::NUM_LINES; k++)
		begin
			rx_byte[k+4] = rcv_data[2*k+1];
			rx_byte[k]   = rcv_data[2*k];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			pair_valid <= 1'b0;
		else
			pair_valid <= data_phase & ~pair_valid;
	end

	// byte 0 arrives first and ends up in the low bits
	always_ff @(posedge clk)
	begin
		if (data_phase && pair_valid)
			rx_shift <= {rx_byte, rx_shift[sd_pkg::WORD_BITS-1:8]};
	end

	//////////////////////////////////////////////////
	// done flags and captured result
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_done <= 1'b0;
			rx_done <= 1'b0;
			crc_err <= '0;
			rx_word <= '0;
		end
		else
		begin
			if (tx_end)
				tx_done <= 1'b1;
			else if (done_clr[0])
				tx_done <= 1'b0;

			if (rx_end)
			begin
				rx_done <= 1'b1;
				crc_err <= crc_error;
				rx_word <= rx_shift;
			end
			else if (done_clr[1])
			begin
				rx_done <= 1'b0;
				crc_err <= '0;  // goes with rx_done
			end
		end
	end

	assign status = '{busy: busy, tx_done: tx_done, rx_done: rx_done,
		crc_err: crc_err, rx_word: rx_word};

endmodule

// File: sd_data_host.sv
`timescale 1ns/1ps

module sd_data_host (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [sd_pkg::APB_AW-1:0]    paddr,
	input  logic                         psel,
	input  logic                         penable,
	input  logic                         pwrite,
	input  logic [31:0]                  pwdata,
	output logic [31:0]                  prdata,
	output logic                         pready,
	output logic                         pslverr,
	output logic [sd_pkg::NUM_LINES-1:0] dat_o,
	output logic [sd_pkg::NUM_LINES-1:0] dat_oe,
	input  logic [sd_pkg::NUM_LINES-1:0] dat_i
);

	sd_pkg::seq_cmd_t                  cmd;
	sd_pkg::line_ctrl_t                line_ctrl;
	sd_pkg::rx_status_t                status;
	logic [1:0]                        done_clr;
	logic [2*sd_pkg::NUM_LINES-1:0]    tx_bits;
	logic [2*sd_pkg::NUM_LINES-1:0]    rcv_data;
	logic [sd_pkg::NUM_LINES-1:0]      crc_error;
	logic [sd_pkg::NUM_LINES-1:0]      start_samp;
	logic                              dat_start;
	logic                              data_phase;
	logic                              busy;
	logic                              tx_end;
	logic                              rx_end;

	sd_apb_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.cmd      (cmd),
		.status   (status),
		.done_clr (done_clr)
	);

	sd_block_seq u_seq (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.dat_start (dat_start),
		.line_ctrl (line_ctrl),
		.tx_bits   (tx_bits),
		.busy      (busy),
		.tx_end    (tx_end),
		.rx_end    (rx_end)
	);

	for (genvar k = 0; k < sd_pkg::NUM_LINES; k++)
	begin : g_line
		sd_dat_line u_line (
			.clk       (clk),
			.rst       (rst),
			.ctrl      (line_ctrl),
			.tx_bits   (tx_bits[2*k +: 2]),
			.dat_i     (dat_i[k]),
			.dat_o     (dat_o[k]),
			.dat_oe    (dat_oe[k]),
			.rcv_data  (rcv_data[2*k +: 2]),
			.crc_error (crc_error[k])
		);
		assign start_samp[k] = rcv_data[2*k];  // newest sample
	end

	assign dat_start  = ~|start_samp;  // start bit seen on all lines
	assign data_phase = (line_ctrl.phase == sd_pkg::PH_DATA);

	sd_rx_result u_result (
		.clk        (clk),
		.rst        (rst),
		.rcv_data   (rcv_data),
		.crc_error  (crc_error),
		.busy       (busy),
		.tx_end     (tx_end),
		.rx_end     (rx_end),
		.data_phase (data_phase),
		.done_clr   (done_clr),
		.status     (status)
	);

endmodule

// File: sd_data_checker.sv
`timescale 1ns/1ps

module sd_data_checker (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic [sd_pkg::NUM_LINES-1:0]                     dat_o,
	input  logic [sd_pkg::NUM_LINES-1:0]                     dat_oe,
	input  logic [sd_pkg::APB_AW-1:0]                        paddr,
	input  logic                                             psel,
	input  logic                                             penable,
	input  logic                                             pwrite,
	input  logic [31:0]                                      prdata,
	input  logic                                             pready,
	input  logic                                             pslverr,
	input  logic [sd_pkg::NUM_LINES-1:0][sd_pkg::CNT_END:0]  exp_frame,
	input  logic                                             rd_check,
	input  logic [31:0]                                      exp_rdata,
	input  logic                                             exp_slverr,
	output int                                               errors,
	output int                                               frames
);

	logic [sd_pkg::NUM_LINES-1:0][sd_pkg::CNT_END:0] cap;  // bit 0 is the start bit
	int                                              idx;

	initial
	begin
		errors = 0;
		frames = 0;
		idx    = 0;
		cap    = '0;
	end

	// one finished block against the model's block
	task automatic compare_block();
		if (idx != int'(sd_pkg::CNT_END) + 1)
		begin
			$display("block on the lines lasted %0d cycles instead of %0d",
				idx, int'(sd_pkg::CNT_END) + 1);
			errors++;
		end
		for (int k = 0; k < sd_pkg::NUM_LINES; k++)
		begin
			if (cap[k] !== exp_frame[k])
			begin
				$display("CHECK FAILED dat_o[%0d] block got=%07h exp=%07h",
					k, cap[k], exp_frame[k]);
				errors++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// pins are sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (rst)
		begin
			idx = 0;
			if (dat_oe !== '0)
			begin
				$display("CHECK FAILED dat_oe in reset got=%h exp=0", dat_oe);
				errors++;
			end
			if (dat_o !== '0)
			begin
				$display("CHECK FAILED dat_o in reset got=%h exp=0", dat_o);
				errors++;
			end
		end
		else if (dat_oe != '0)
		begin
			if (dat_oe != '1)
			begin
				$display("the DAT lines are not enabled together, dat_oe=%h", dat_oe);
				errors++;
			end
			if (idx > int'(sd_pkg::CNT_END))
			begin
				$display("block keeps driving past its end bit");  // once per extra cycle
				errors++;
			end
			else
			begin
				for (int k = 0; k < sd_pkg::NUM_LINES; k++)
					cap[k][idx] = dat_o[k];
				idx++;
			end
		end
		else if (idx != 0)
		begin
			compare_block();
			frames++;
			idx = 0;
			cap = '0;
		end

		// every access completes in its access phase
		if (!rst && psel && penable && pready !== 1'b1)
		begin
			$display("CHECK FAILED pready addr=%02h got=%h exp=1", paddr, pready);
			errors++;
		end

		// apb read data is checked only where the testbench knows the answer
		if (!rst && rd_check && psel && penable && !pwrite)
		begin
			if (prdata !== exp_rdata)
			begin
				$display("CHECK FAILED prdata addr=%02h got=%08h exp=%08h",
					paddr, prdata, exp_rdata);
				errors++;
			end
			if (pslverr !== exp_slverr)
			begin
				$display("CHECK FAILED pslverr addr=%02h got=%h exp=%h",
					paddr, pslverr, exp_slverr);
				errors++;
			end
		end
	end

endmodule

// File: tb_sd_data_host.sv
`timescale 1ns/1ps

module tb_sd_data_host;

	typedef logic [sd_pkg::NUM_LINES-1:0][sd_pkg::CNT_END:0] frame_t;

	logic                         clk;
	logic                         rst;
	logic [sd_pkg::APB_AW-1:0]    paddr;
	logic                         psel;
	logic                         penable;
	logic                         pwrite;
	logic [31:0]                  pwdata;
	logic [31:0]                  prdata;
	logic                         pready;
	logic                         pslverr;
	logic [sd_pkg::NUM_LINES-1:0] dat_o;
	logic [sd_pkg::NUM_LINES-1:0] dat_oe;
	logic [sd_pkg::NUM_LINES-1:0] dat_i;
	frame_t                       exp_frame;
	logic                         rd_check;
	logic [31:0]                  exp_rdata;
	logic                         exp_slverr;
	int                           chk_errors;
	int                           chk_frames;
	int                           flow_errors;
	int                           failed_tests;
	int                           test_no;
	int                           cycles = 0;
	int                           limit;
	int                           n_words = 20;
	int                           n_bad = 10;

	sd_data_host UUT (
		.clk     (clk),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.dat_o   (dat_o),
		.dat_oe  (dat_oe),
		.dat_i   (dat_i)
	);

	sd_data_checker u_check (
		.clk        (clk),
		.rst        (rst),
		.dat_o      (dat_o),
		.dat_oe     (dat_oe),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.exp_frame  (exp_frame),
		.rd_check   (rd_check),
		.exp_rdata  (exp_rdata),
		.exp_slverr (exp_slverr),
		.errors     (chk_errors),
		.frames     (chk_frames)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("run stopped after %0d cycles, test %0d never finished", cycles, test_no);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// model of the block format
	//////////////////////////////////////////////////

	function automatic logic [15:0] next_crc(input logic [15:0] crc, input logic d);
		logic fb;
		fb = d ^ crc[15];
		return {crc[14:0], 1'b0} ^ (fb ? sd_pkg::CRC_POLY : 16'h0000);
	endfunction

	// start, 8 data bits, crc msb first, end
	function automatic frame_t build_frame(input logic [31:0] word);
		frame_t      f;
		logic [15:0] crc;
		logic [7:0]  b;
		for (int k = 0; k < sd_pkg::NUM_LINES; k++)
		begin
			crc     = '0;
			f[k][0] = 1'b0;
			for (int n = 0; n < sd_pkg::BLOCK_BYTES; n++)
			begin
				b           = word[8*n +: 8];
				f[k][2*n+1] = b[k+4];  // high nibble bit first
				f[k][2*n+2] = b[k];
				crc         = next_crc(crc, b[k+4]);
				crc         = next_crc(crc, b[k]);
			end
			for (int i = 0; i < sd_pkg::CRC_BITS; i++)
				f[k][sd_pkg::DATA_BITS+1+i] = crc[sd_pkg::CRC_BITS-1-i];
			f[k][sd_pkg::CNT_END] = 1'b1;
		end
		return f;
	endfunction

	function automatic int total_errors();
		return flow_errors + chk_errors;
	endfunction

	//////////////////////////////////////////////////
	// apb master and card
	//////////////////////////////////////////////////

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		paddr   = addr;
		pwrite  = 1'b1;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);  // access edge
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		#1;
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_read(input logic [7:0] addr, input logic [31:0] value,
		input logic err);
		logic [31:0] rdata;
		exp_rdata  = value;
		exp_slverr = err;
		rd_check   = 1'b1;
		read_reg(addr, rdata);
		rd_check   = 1'b0;
	endtask

	task automatic wait_flag(input int bit_no, input string name);
		logic [31:0] st;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[bit_no] && polls < 40)
		begin
			read_reg(sd_pkg::ADDR_STATUS, st);
			polls++;
		end
		if (!st[bit_no])
		begin
			$display("%s did not set within %0d status reads", name, polls);
			flow_errors++;
		end
	endtask

	task automatic count_blocks(input int expected);
		if (chk_frames != expected)
		begin
			$display("expected %0d blocks on the lines so far, saw %0d", expected, chk_frames);
			flow_errors++;
		end
	endtask

	task automatic card_drive(input frame_t f);
		for (int j = 0; j <= int'(sd_pkg::CNT_END); j++)
		begin
			@(posedge clk);
			#1;
			for (int k = 0; k < sd_pkg::NUM_LINES; k++)
				dat_i[k] = f[k][j];
		end
		@(posedge clk);
		#1;
		dat_i = '1;  // back to idle high
	endtask

	task automatic report_test(input string name, input int base);
		int errs;
		errs = total_errors() - base;
		if (errs != 0)
			failed_tests++;
		$display("test %0d %s: %s (%0d errors)", test_no, name, errs ? "failed" : "ok", errs);
	endtask

	//////////////////////////////////////////////////
	// test bodies
	//////////////////////////////////////////////////

	task automatic tx_block(input logic [31:0] word);
		int mark;
		exp_frame = build_frame(word);
		mark      = chk_frames;
		write_reg(sd_pkg::ADDR_TXDATA, word);
		expect_read(sd_pkg::ADDR_TXDATA, word, 1'b0);
		write_reg(sd_pkg::ADDR_CTRL, 32'h1);
		wait_flag(1, "tx_done");
		expect_read(sd_pkg::ADDR_STATUS, 32'h2, 1'b0);
		write_reg(sd_pkg::ADDR_STATUS, 32'h2);
		expect_read(sd_pkg::ADDR_STATUS, 32'h0, 1'b0);
		count_blocks(mark + 1);
	endtask

	task automatic rx_block(input logic [31:0] word, input logic [3:0] mask);
		frame_t f;
		int     gap;
		int     pos;
		f = build_frame(word);
		for (int k = 0; k < sd_pkg::NUM_LINES; k++)
		begin
			if (mask[k])
			begin
				pos = $urandom_range(sd_pkg::CRC_BITS - 1, 0);
				f[k][sd_pkg::DATA_BITS+1+pos] = ~f[k][sd_pkg::DATA_BITS+1+pos];
			end
		end
		gap = $urandom_range(7, 0);
		write_reg(sd_pkg::ADDR_CTRL, 32'h2);
		repeat (gap) @(posedge clk);
		card_drive(f);
		wait_flag(2, "rx_done");
		expect_read(sd_pkg::ADDR_RXDATA, word, 1'b0);
		expect_read(sd_pkg::ADDR_STATUS, {24'b0, mask, 4'h4}, 1'b0);
		write_reg(sd_pkg::ADDR_STATUS, 32'h4);
		expect_read(sd_pkg::ADDR_STATUS, 32'h0, 1'b0);  // crc_err goes too
	endtask

	task automatic ignore_ctrl_while_busy(input logic [31:0] w1, input logic [31:0] w2);
		int mark;
		exp_frame = build_frame(w1);
		mark      = chk_frames;
		write_reg(sd_pkg::ADDR_TXDATA, w1);
		write_reg(sd_pkg::ADDR_CTRL, 32'h1);
		write_reg(sd_pkg::ADDR_TXDATA, w2);  // mid block
		write_reg(sd_pkg::ADDR_CTRL, 32'h3);
		expect_read(sd_pkg::ADDR_STATUS, 32'h1, 1'b0);  // block still on the lines
		wait_flag(1, "tx_done");
		expect_read(sd_pkg::ADDR_STATUS, 32'h2, 1'b0);
		write_reg(sd_pkg::ADDR_STATUS, 32'h2);
		repeat (40) @(posedge clk);  // room for a second block
		expect_read(sd_pkg::ADDR_STATUS, 32'h0, 1'b0);
		expect_read(sd_pkg::ADDR_TXDATA, w2, 1'b0);
		count_blocks(mark + 1);
	endtask

	initial
	begin
		logic [31:0] word;
		logic [3:0]  mask;
		int          base;
		rst          = 1'b1;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		dat_i        = '1;
		exp_frame    = '0;
		rd_check     = 1'b0;
		exp_rdata    = '0;
		exp_slverr   = 1'b0;
		flow_errors  = 0;
		failed_tests = 0;
		test_no      = 0;
		limit        = (2 * n_words + n_bad + 2) * 60 + 16;
		void'($urandom(32'h621561f3));
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		test_no = 1;
		base    = total_errors();
		expect_read(sd_pkg::ADDR_STATUS, 32'h0, 1'b0);
		expect_read(sd_pkg::ADDR_RXDATA, 32'h0, 1'b0);
		expect_read(sd_pkg::ADDR_TXDATA, 32'h0, 1'b0);
		expect_read(8'h10, 32'h0, 1'b1);  // unmapped
		report_test("reset state", base);

		test_no = 2;
		base    = total_errors();
		repeat (n_words)
		begin
			word = $urandom();
			tx_block(word);
		end
		report_test("transmit", base);

		test_no = 3;
		base    = total_errors();
		repeat (n_words)
		begin
			word = $urandom();
			rx_block(word, 4'h0);
		end
		report_test("receive", base);

		test_no = 4;
		base    = total_errors();
		repeat (n_bad)
		begin
			word = $urandom();
			mask = 4'($urandom_range(15, 1));
			rx_block(word, mask);
		end
		report_test("receive bad crc", base);

		test_no = 5;
		base    = total_errors();
		ignore_ctrl_while_busy($urandom(), $urandom());
		report_test("ctrl while busy", base);

		$display("%0d tests run, %0d failed, %0d errors", test_no, failed_tests, total_errors());
		if (total_errors() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: flist.f
sd_pkg.sv
crc16.sv
sd_dat_line.sv
sd_apb_regs.sv
sd_block_seq.sv
sd_rx_result.sv
sd_data_host.sv
sd_data_checker.sv
tb_sd_data_host.sv

// File: Makefile
# Verilator build and run of the SD data path testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_data_host
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
